// File: processor.f
hw/isaPkg.sv
hw/busPkg.sv
hw/alu.sv
hw/registerBlock.sv
hw/sequencer.sv
hw/processor.sv
verif/clockGen.sv
verif/processorTb.sv

// File: run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f processor.f --top-module processorTb -o processorSim

# Output is shown and searched for the pass line
./obj_dir/processorSim | tee /dev/stderr | grep -qx "Test passed"
echo "Simulation reported a pass"

// File: verif/processorTb.sv
module processorTb;

    import isaPkg::*;
    import busPkg::*;

    logic       CLK;
    logic       RESET;
    byteT       busDataIn;
    busReqT     busReq;
    byteT       romAddress;
    romByteT    romData;
    logic [1:0] interruptRaise;
    logic [1:0] interruptAck;

    // Memory models, write flags and the ordered write record {addr, data}
    byteT        rom [256];
    byteT        ram [256];
    logic        written [256];
    logic [15:0] writeLog [$];
    byteT        progPtr;
    logic [15:0] lfsrState;

    // Request to the checking process
    event  checkNow;
    string chkName;
    byteT  chkAddr;
    byteT  chkExp;

    clockGen i_clockGen (.CLK(CLK), .RESET(RESET));

    processor i_dut (
        .CLK            (CLK),
        .RESET          (RESET),
        .busDataIn      (busDataIn),
        .busReq         (busReq),
        .romAddress     (romAddress),
        .romData        (romData),
        .interruptRaise (interruptRaise),
        .interruptAck   (interruptAck)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic reportMismatch(input string name, input byteT expected, input byteT actual);
        stopRun($sformatf("ERROR %s: expected %02h, actual %02h", name, expected, actual));
    endtask

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One LFSR step per bit
    task automatic randomByte(output byteT value);
        value = '0;
        for (int i = 0; i < 8; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[6:0], lfsrState[0]};
        end
    endtask

    // Expected ALU result, modulo 256
    function automatic byteT refAlu(input logic [3:0] op, input byteT a, input byteT b);
        logic [15:0] product;
        product = 16'(a) * 16'(b);
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return product[7:0];
            4'd3:    return {a[6:0], 1'b0};
            4'd4:    return {1'b0, a[7:1]};
            4'd5:    return a + 8'd1;
            4'd6:    return b + 8'd1;
            4'd7:    return a - 8'd1;
            4'd8:    return b - 8'd1;
            4'd9:    return (a == b) ? 8'd1 : 8'd0;
            4'd10:   return (a > b) ? 8'd1 : 8'd0;
            4'd11:   return (a < b) ? 8'd1 : 8'd0;
            default: return a;
        endcase
    endfunction

    // One clock of both memories, inputs change 2 after the edge
    task automatic nextCycle();
        byteT romQ;
        byteT ramQ;
        @(posedge CLK);
        // Sampled before the DUT registers move, read returns old data
        romQ = rom[romAddress];
        ramQ = ram[busReq.addr];
        if (busReq.we) begin
            ram[busReq.addr] = busReq.dataOut;
            written[busReq.addr] = 1'b1;
            writeLog.push_back({busReq.addr, busReq.dataOut});
        end
        #2;
        romData = romQ;
        busDataIn = ramQ;
    endtask

    // Every ROM byte decodes as goto idle until a program lands on it
    task automatic clearMemories();
        for (int i = 0; i < 256; i++) begin
            rom[8'(i)] = {i[7:4] ^ i[3:0], 4'h8};
            ram[8'(i)] = 8'(i) ^ 8'hA5;
            written[8'(i)] = 1'b0;
        end
        writeLog.delete();
        progPtr = '0;
    endtask

    task automatic emit(input byteT value);
        rom[progPtr] = value;
        progPtr++;
    endtask

    task automatic checkRam(input string name, input byteT addr, input byteT expected);
        chkName = name;
        chkAddr = addr;
        chkExp = expected;
        -> checkNow;
        nextCycle();
    endtask

    // Raise, wait for the ack, then expect it gone a cycle later
    task automatic raiseAndWaitAck(input logic [1:0] lines, output logic [1:0] ackSeen);
        int count;
        interruptRaise = lines;
        ackSeen = 2'b00;
        count = 0;
        while (ackSeen == 2'b00 && count < 10) begin
            nextCycle();
            ackSeen = interruptAck;
            count++;
        end
        assert (ackSeen != 2'b00) else stopRun("the interrupt ack never arrived");
        interruptRaise = 2'b00;
        nextCycle();
        assert (interruptAck == 2'b00) else stopRun("the interrupt ack lasted over one cycle");
    endtask

    // ROM address sits on the vector only while idle
    task automatic waitIdle();
        int count;
        count = 0;
        while (romAddress == 8'hFF && count < 10) begin
            nextCycle();
            count++;
        end
        assert (romAddress != 8'hFF) else stopRun("the thread never started after its ack");
        count = 0;
        while (romAddress != 8'hFF && count < 300) begin
            nextCycle();
            count++;
        end
        assert (romAddress == 8'hFF) else stopRun("the program never returned to idle");
    endtask

    task automatic runThread(input logic [1:0] lines, output logic [1:0] ackSeen);
        raiseAndWaitAck(lines, ackSeen);
        waitIdle();
    endtask

    //////////////////////////////
    // Checker
    //////////////////////////////

    always @(checkNow) begin
        assert (written[chkAddr])
            else stopRun($sformatf("%s: nothing was written to %02h", chkName, chkAddr));
        assert (ram[chkAddr] == chkExp)
            else reportMismatch(chkName, chkExp, ram[chkAddr]);
    end

    //////////////////////////////
    // Tests
    //////////////////////////////

    initial begin
        byteT       opA;
        byteT       opB;
        byteT       expected;
        logic [1:0] ack;
        byteT       callWrites [$];
        int         count;

        interruptRaise = 2'b00;
        romData = '0;
        busDataIn = '0;
        lfsrState = 16'h0001;
        clearMemories();

        // Reset and ack pulses
        count = 0;
        while (RESET !== 1'b0 && count < 20) begin
            nextCycle();
            count++;
        end
        assert (RESET === 1'b0) else stopRun("reset was never released");
        nextCycle();
        assert (busReq.we == 1'b0) else reportMismatch("reset we", 8'h00, 8'(busReq.we));
        assert (interruptAck == 2'b00) else reportMismatch("reset ack", 8'h00, 8'(interruptAck));
        assert (busReq.addr == 8'hFF) else reportMismatch("reset bus addr", 8'hFF, busReq.addr);

        rom[8'hFE] = 8'h40;
        rom[8'hFF] = 8'h40;
        progPtr = 8'h40;
        emit(8'h08);
        runThread(2'b10, ack);
        assert (ack == 2'b10) else reportMismatch("ack line 1", 8'h02, 8'(ack));
        runThread(2'b11, ack);
        assert (ack == 2'b01) else reportMismatch("ack both lines", 8'h01, 8'(ack));

        // Every ALU operation through A and through B
        for (int op = 0; op < 12; op++) begin
            for (int path = 0; path < 2; path++) begin
                clearMemories();
                randomByte(opA);
                randomByte(opB);
                ram[8'h10] = opA;
                ram[8'h11] = opB;
                rom[8'hFF] = 8'h00;
                emit(8'h00);
                emit(8'h10);
                emit(8'h01);
                emit(8'h11);
                emit({4'(op), 4'(4 + path)});
                emit(8'(2 + path));
                emit(8'h20);
                emit(8'h08);
                runThread(2'b01, ack);
                checkRam($sformatf("alu op %0d into %s", op, (path == 1) ? "B" : "A"),
                         8'h20, refAlu(4'(op), opA, opB));
            end
        end

        // Branch on each compare, equal operands once
        for (int op = 9; op < 12; op++) begin
            for (int k = 0; k < 3; k++) begin
                clearMemories();
                randomByte(opA);
                randomByte(opB);
                if (k == 0) begin
                    opB = opA;
                end
                ram[8'h10] = opA;
                ram[8'h11] = opB;
                ram[8'h12] = 8'h55;
                ram[8'h13] = 8'hAA;
                rom[8'hFF] = 8'h00;
                emit(8'h00);
                emit(8'h10);
                emit(8'h01);
                emit(8'h11);
                emit({4'(op), 4'h6});
                emit(8'h10);
                // Fall-through marker
                emit(8'h00);
                emit(8'h12);
                emit(8'h02);
                emit(8'h20);
                emit(8'h08);
                // Taken marker
                progPtr = 8'h10;
                emit(8'h00);
                emit(8'h13);
                emit(8'h02);
                emit(8'h20);
                emit(8'h08);
                runThread(2'b01, ack);
                expected = (refAlu(4'(op), opA, opB) != 8'h00) ? 8'hAA : 8'h55;
                checkRam($sformatf("branch op %0d run %0d", op, k), 8'h20, expected);
            end
        end

        // Goto over a poisoning write, then a fresh interrupt
        clearMemories();
        randomByte(opA);
        ram[8'h10] = opA;
        rom[8'hFF] = 8'h00;
        rom[8'hFE] = 8'h40;
        emit(8'h00);
        emit(8'h10);
        emit(8'h02);
        emit(8'h20);
        emit(8'h07);
        emit(8'h10);
        emit(8'h02);
        emit(8'h21);
        emit(8'h08);
        progPtr = 8'h10;
        emit(8'h02);
        emit(8'h22);
        emit(8'h08);
        progPtr = 8'h40;
        emit(8'h08);
        runThread(2'b01, ack);
        checkRam("goto first write", 8'h20, opA);
        checkRam("goto second write", 8'h22, opA);
        assert (!written[8'h21]) else stopRun("the write skipped by goto was executed");
        runThread(2'b10, ack);
        assert (ack == 2'b10) else reportMismatch("ack after goto idle", 8'h02, 8'(ack));

        // Call and return, writes 1 2 3 at 0x30
        clearMemories();
        ram[8'h10] = 8'h01;
        ram[8'h11] = 8'h02;
        ram[8'h12] = 8'h03;
        rom[8'hFF] = 8'h00;
        emit(8'h00);
        emit(8'h10);
        emit(8'h02);
        emit(8'h30);
        emit(8'h09);
        emit(8'h20);
        emit(8'h00);
        emit(8'h12);
        emit(8'h02);
        emit(8'h30);
        emit(8'h08);
        progPtr = 8'h20;
        emit(8'h00);
        emit(8'h11);
        emit(8'h02);
        emit(8'h30);
        emit(8'h0A);
        runThread(2'b01, ack);
        foreach (writeLog[i]) begin
            if (writeLog[i][15:8] == 8'h30) begin
                callWrites.push_back(writeLog[i][7:0]);
            end
        end
        assert (callWrites.size() == 3)
            else stopRun($sformatf("call test saw %0d writes at 30", callWrites.size()));
        for (int i = 0; i < 3; i++) begin
            assert (callWrites[i] == 8'(i + 1))
                else reportMismatch($sformatf("call write %0d", i), 8'(i + 1), callWrites[i]);
        end

        $display("Test passed");
        $finish;
    end

endmodule

// File: verif/clockGen.sv
module clockGen (
    output logic CLK,
    output logic RESET
);

    // Free-running clock, period 40
    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Reset for the first 4 edges, released just after an edge
    initial begin
        RESET = 1'b1;
        repeat (4) @(posedge CLK);
        #2 RESET = 1'b0;
    end

endmodule

// File: hw/processor.sv
module processor (
    input  logic            CLK,
    input  logic            RESET,
    input  busPkg::byteT    busDataIn,
    output busPkg::busReqT  busReq,
    output busPkg::byteT    romAddress,
    input  isaPkg::romByteT romData,
    input  logic [1:0]      interruptRaise,
    output logic [1:0]      interruptAck
);

    import isaPkg::*;
    import busPkg::*;

    // Sequencer to register block
    regCtrlT  regCtrl;
    // Register contents, to sequencer and ALU
    regStateT regState;

    // ALU operation in, result out
    aluOpT aluOp;
    byteT  aluResult;

    // Fetch, decode, execute and bus control
    sequencer i_sequencer (
        .CLK            (CLK),
        .RESET          (RESET),
        .romData        (romData),
        .romAddress     (romAddress),
        .busDataIn      (busDataIn),
        .busReq         (busReq),
        .interruptRaise (interruptRaise),
        .interruptAck   (interruptAck),
        .regState       (regState),
        .aluResult      (aluResult),
        .aluOp          (aluOp),
        .regCtrl        (regCtrl)
    );

    // A, B and call context
    registerBlock i_registerBlock (
        .CLK      (CLK),
        .RESET    (RESET),
        .regCtrl  (regCtrl),
        .regState (regState)
    );

    // Zero-latency datapath
    alu i_alu (
        .a      (regState.a),
        .b      (regState.b),
        .aluOp  (aluOp),
        .result (aluResult)
    );

endmodule

// File: hw/sequencer.sv
module sequencer (
    input  logic             CLK,
    input  logic             RESET,
    input  isaPkg::romByteT  romData,
    output busPkg::byteT     romAddress,
    input  busPkg::byteT     busDataIn,
    output busPkg::busReqT   busReq,
    input  logic [1:0]       interruptRaise,
    output logic [1:0]       interruptAck,
    input  busPkg::regStateT regState,
    input  busPkg::byteT     aluResult,
    output isaPkg::aluOpT    aluOp,
    output busPkg::regCtrlT  regCtrl
);

    import isaPkg::*;
    import busPkg::*;

    // One chain of states per instruction, each ends back in decode
    typedef enum logic [4:0] {
        idle,
        threadVector,
        threadLoad,
        threadSettle,
        decode,
        readFetch,
        readIssue,
        readWait,
        readStore,
        writeFetch,
        writeIssue,
        mathsStore,
        mathsSettle,
        branchTest,
        branchSettle,
        jumpFetch,
        jumpLoad,
        jumpSettle,
        callSave,
        returnLoad,
        returnSettle,
        idleReturn
    } stateT;

    stateT state;

    // Program counter and one-cycle operand offset
    byteT pc;
    logic offset;

    // Registered bus request
    byteT busAddr;
    logic busWe;
    byteT busDataOut;

    // Register B is the source or destination when set
    logic destB;

    // ROM answers one cycle after the address
    assign romAddress = pc + byteT'(offset);

    // ROM still holds the instruction in the cycle after decode
    assign aluOp = romData.instr.aluOp;

    assign busReq = '{addr: busAddr, dataOut: busDataOut, we: busWe};

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= idle;
            pc           <= irqVector0;
            offset       <= 1'b0;
            busAddr      <= idleBusAddr;
            busWe        <= 1'b0;
            destB        <= 1'b0;
            interruptAck <= 2'b00;
        end else begin
            // Pulses and the offset last one cycle only
            offset       <= 1'b0;
            busAddr      <= idleBusAddr;
            busWe        <= 1'b0;
            interruptAck <= 2'b00;

            case (state)
                // Wait for a raise, line 0 wins
                idle: begin
                    if (interruptRaise[0]) begin
                        pc           <= irqVector0;
                        interruptAck <= 2'b01;
                        state        <= threadVector;
                    end else if (interruptRaise[1]) begin
                        pc           <= irqVector1;
                        interruptAck <= 2'b10;
                        state        <= threadVector;
                    end
                end

                // Vector byte is on its way from ROM
                threadVector: state <= threadLoad;
                threadLoad: begin
                    pc    <= romData.addr;
                    state <= threadSettle;
                end
                // First opcode is on its way
                threadSettle: state <= decode;

                // Point ROM at the operand byte for every opcode
                decode: begin
                    offset <= 1'b1;
                    case (romData.instr.opType)
                        readA: begin
                            destB <= 1'b0;
                            state <= readFetch;
                        end
                        readB: begin
                            destB <= 1'b1;
                            state <= readFetch;
                        end
                        writeA: begin
                            destB <= 1'b0;
                            state <= writeFetch;
                        end
                        writeB: begin
                            destB <= 1'b1;
                            state <= writeFetch;
                        end
                        mathsA: begin
                            destB <= 1'b0;
                            state <= mathsStore;
                        end
                        mathsB: begin
                            destB <= 1'b1;
                            state <= mathsStore;
                        end
                        branch:   state <= branchTest;
                        gotoAddr: state <= jumpFetch;
                        call:     state <= callSave;
                        ret:      state <= returnLoad;
                        // Goto idle and any undefined opcode
                        default:  state <= idleReturn;
                    endcase
                end

                // Read, operand address then memory data
                readFetch: state <= readIssue;
                readIssue: begin
                    busAddr <= romData.addr;
                    state   <= readWait;
                end
                readWait: begin
                    pc    <= pc + byteT'(2);
                    state <= readStore;
                end
                // Data lands in the register through regCtrl
                readStore: state <= decode;

                // Write, strobe is seen during the next decode
                writeFetch: begin
                    pc    <= pc + byteT'(2);
                    state <= writeIssue;
                end
                writeIssue: begin
                    busAddr <= romData.addr;
                    busWe   <= 1'b1;
                    state   <= decode;
                end

                // Maths, one byte long
                mathsStore: begin
                    pc    <= pc + byteT'(1);
                    state <= mathsSettle;
                end
                mathsSettle: state <= decode;

                // Taken branch joins the goto path, one cycle longer
                branchTest: begin
                    if (aluResult != '0) begin
                        state <= jumpLoad;
                    end else begin
                        pc    <= pc + byteT'(2);
                        state <= branchSettle;
                    end
                end
                branchSettle: state <= decode;

                // Goto, also the tail of call
                jumpFetch: state <= jumpLoad;
                jumpLoad: begin
                    pc    <= romData.addr;
                    state <= jumpSettle;
                end
                jumpSettle: state <= decode;

                // Return address saved through regCtrl
                callSave: state <= jumpLoad;

                returnLoad: begin
                    pc    <= regState.callContext;
                    state <= returnSettle;
                end
                returnSettle: state <= decode;

                // Park the counter and wait for the next raise
                idleReturn: begin
                    pc    <= irqVector0;
                    state <= idle;
                end

                default: state <= idle;
            endcase
        end
    end

    // Write data, taken from the selected register
    always_ff @(posedge CLK) begin
        if (state == writeIssue) begin
            busDataOut <= destB ? regState.b : regState.a;
        end
    end

    //////////////////////////////
    // Register block control
    //////////////////////////////

    always_comb begin
        regCtrl              = '0;
        regCtrl.value        = (state == readStore) ? busDataIn : aluResult;
        // Address of the instruction after the call
        regCtrl.contextValue = pc + byteT'(2);
        case (state)
            readStore, mathsStore: begin
                regCtrl.writeA = !destB;
                regCtrl.writeB = destB;
            end
            callSave: regCtrl.writeContext = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: hw/registerBlock.sv
module registerBlock (
    input  logic             CLK,
    input  logic             RESET,
    input  busPkg::regCtrlT  regCtrl,
    output busPkg::regStateT regState
);

    import busPkg::*;

    // Working registers and saved return address
    byteT regA;
    byteT regB;
    byteT regContext;

    //////////////////////////////
    // Data registers
    //////////////////////////////

    // A and B share one write value, either or both may load
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
        end else begin
            if (regCtrl.writeA) begin
                regA <= regCtrl.value;
            end
            if (regCtrl.writeB) begin
                regB <= regCtrl.value;
            end
        end
    end

    //////////////////////////////
    // Call context
    //////////////////////////////

    // One level deep, a nested call overwrites it
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regContext <= '0;
        end else if (regCtrl.writeContext) begin
            regContext <= regCtrl.contextValue;
        end
    end

    assign regState = '{a: regA, b: regB, callContext: regContext};

endmodule

// File: hw/alu.sv
module alu (
    input  busPkg::byteT  a,
    input  busPkg::byteT  b,
    input  isaPkg::aluOpT aluOp,
    output busPkg::byteT  result
);

    import isaPkg::*;
    import busPkg::*;

    // Purely combinational, all results wrap modulo 256
    always_comb begin
        case (aluOp)
            // Arithmetic on both operands
            add:         result = a + b;
            subtract:    result = a - b;
            // Low byte of the product only
            multiply:    result = a * b;

            // Single-bit shifts of A, zero filled
            shiftLeftA:  result = a << 1;
            shiftRightA: result = a >> 1;

            // Step one operand up or down
            incrementA:  result = a + byteT'(1);
            incrementB:  result = b + byteT'(1);
            decrementA:  result = a - byteT'(1);
            decrementB:  result = b - byteT'(1);

            // Compares give 1 for true, 0 for false
            // The branch takes any nonzero result
            equal:       result = byteT'(a == b);
            greater:     result = byteT'(a > b);
            less:        result = byteT'(a < b);

            // Unused codes pass A through
            default:     result = a;
        endcase
    end

endmodule

// File: hw/busPkg.sv
package busPkg;

    // One data byte sized from the instruction set width
    typedef logic [isaPkg::dataWidth-1:0] byteT;

    // External data bus request of 17 bits
    typedef struct packed {
        byteT addr;
        byteT dataOut;
        logic we;
    } busReqT;

    // Register block write control of 19 bits
    typedef struct packed {
        logic writeA;
        logic writeB;
        byteT value;
        logic writeContext;
        byteT contextValue;
    } regCtrlT;

    // Register block contents of 24 bits
    typedef struct packed {
        byteT a;
        byteT b;
        // Return address saved by call
        byteT callContext;
    } regStateT;

endpackage

// File: hw/isaPkg.sv
package isaPkg;

    // Width of data words and of both address spaces
    localparam int dataWidth = 8;

    //////////////////////////////
    // Instruction fields
    //////////////////////////////

    // Low nibble of the instruction byte
    typedef enum logic [3:0] {
        readA    = 4'd0,
        readB    = 4'd1,
        writeA   = 4'd2,
        writeB   = 4'd3,
        mathsA   = 4'd4,
        mathsB   = 4'd5,
        branch   = 4'd6,
        gotoAddr = 4'd7,
        gotoIdle = 4'd8,
        call     = 4'd9,
        ret      = 4'd10
    } opTypeT;

    // High nibble, only meaningful for maths and branch
    typedef enum logic [3:0] {
        add         = 4'd0,
        subtract    = 4'd1,
        multiply    = 4'd2,
        shiftLeftA  = 4'd3,
        shiftRightA = 4'd4,
        incrementA  = 4'd5,
        incrementB  = 4'd6,
        decrementA  = 4'd7,
        decrementB  = 4'd8,
        equal       = 4'd9,
        greater     = 4'd10,
        less        = 4'd11
    } aluOpT;

    typedef struct packed {
        aluOpT  aluOp;
        opTypeT opType;
    } instrT;

    // Opcode in decode, operand address in the states after it
    typedef union packed {
        instrT                 instr;
        logic [dataWidth-1:0] addr;
    } romByteT;

    //////////////////////////////
    // Fixed addresses
    //////////////////////////////

    // ROM bytes holding thread start addresses
    localparam logic [dataWidth-1:0] irqVector0 = 8'hFF;
    localparam logic [dataWidth-1:0] irqVector1 = 8'hFE;

    // Parked bus address between accesses
    localparam logic [dataWidth-1:0] idleBusAddr = 8'hFF;

endpackage
